/* Bender.yml */
package:
  name: qs_accel

sources:
  # Synthesizable RTL, packages first
  - include_dirs:
      - source
    files:
      - source/qs_sort_pkg.sv
      - source/qs_stack_pkg.sv
      - source/spsram.sv
      - source/qs_stack.sv
      - source/qs_engine.sv
      - source/qs_top.sv

  # Testbench with top module qs_tb
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clock.sv
      - verif/qs_stack_props.sv
      - verif/qs_tb.sv

/* build.f */
+incdir+source
source/qs_sort_pkg.sv
source/qs_stack_pkg.sv
source/spsram.sv
source/qs_stack.sv
source/qs_engine.sv
source/qs_top.sv
verif/tb_clock.sv
verif/qs_stack_props.sv
verif/qs_tb.sv

/* source/qs_cfg.svh */
// Quicksort accelerator configuration
`ifndef QS_CFG_SVH
`define QS_CFG_SVH

// Number of keys sorted in one run
`define QS_KEYS 16

// Width of one unsigned key in bits
`define QS_KEY_W 16

// Depth of the range stack
// Ranges on the stack are disjoint and hold at least two keys each,
// so at most half of QS_KEYS ranges are ever stored at once
`define QS_STACK_N `QS_KEYS

`endif

/* source/qs_engine.sv */
// Quicksort control FSM
`include "qs_cfg.svh"

module qs_engine
  import qs_sort_pkg::*;
  import qs_stack_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic               busy,
  output logic               done,
  output logic               k_en,
  output logic               k_wen,
  output idx_t               k_addr,
  output key_t               k_din,
  input  key_t               k_dout,
  output logic               cmd_vld,
  output logic               cmd_push,
  output logic [STACK_W-1:0] cmd_push_dat,
  output logic               cmd_clr,
  input  logic [STACK_W-1:0] cmd_pop_dat_r,
  input  logic               empty_r,
  input  logic               full_r
);

  eng_state_t  state_r;

  // Current range and partition cursors
  idx_t        lo_r;
  idx_t        hi_r;
  idx_t        i_r;
  idx_t        j_r;
  key_t        pivot_r;

  // Key held across the two halves of a swap
  key_t        jkey_r;
  key_t        ikey_r;
  logic        ph_r;

  // Side ranges waiting to be pushed
  range_t      push_a_r;
  range_t      push_b_r;
  logic        push_a_vld_r;
  logic        push_b_vld_r;

  stack_word_u top_word;
  stack_word_u push_word;
  logic        le_pivot;
  logic        last_j;
  logic        accept;

  // Popped top decoded as a range
  assign top_word.raw = cmd_pop_dat_r;

  assign push_word.rng = push_a_vld_r ? push_a_r : push_b_r;
  assign cmd_push_dat  = push_word.raw;

  assign le_pivot = (k_dout <= pivot_r);
  assign last_j   = (j_r == hi_r - 1'b1);
  assign accept   = ((state_r == IDLE) || (state_r == DONE)) && start;

  // Stack commands
  always_comb begin
    cmd_vld  = 1'b0;
    cmd_push = 1'b0;
    cmd_clr  = 1'b0;
    case (state_r)
      IDLE, DONE: begin
        cmd_vld = accept;
        cmd_clr = accept;
      end
      POP: begin
        cmd_vld = ~empty_r;
      end
      PUSH: begin
        // Depth covers the worst case, so full_r only acts as a guard
        cmd_vld  = (push_a_vld_r | push_b_vld_r) & ~full_r;
        cmd_push = 1'b1;
      end
      default: begin
        cmd_vld = 1'b0;
      end
    endcase
  end

  // Key memory access
  always_comb begin
    k_en   = 1'b0;
    k_wen  = 1'b0;
    k_addr = j_r;
    k_din  = jkey_r;
    case (state_r)
      PIVOT: begin
        k_en   = 1'b1;
        k_addr = hi_r;
      end
      SCAN_RD: begin
        k_en   = 1'b1;
        k_addr = j_r;
      end
      SCAN_SW: begin
        // First half reads the old key at i while writing the small key
        k_en   = 1'b1;
        k_wen  = 1'b1;
        k_addr = ph_r ? j_r : i_r;
        k_din  = ph_r ? ikey_r : jkey_r;
      end
      FINAL_SW: begin
        // Pivot goes to i, and the key it displaces goes to hi
        k_en   = 1'b1;
        k_wen  = 1'b1;
        k_addr = ph_r ? hi_r : i_r;
        k_din  = ph_r ? ikey_r : pivot_r;
      end
      default: begin
        k_en = 1'b0;
      end
    endcase
  end

  // Datapath registers carry no reset
  always_ff @(posedge clk) begin
    case (state_r)
      IDLE, DONE: begin
        push_a_r <= '{lo: '0, hi: idx_t'(`QS_KEYS - 1)};
      end
      POP: begin
        lo_r <= top_word.rng.lo;
        hi_r <= top_word.rng.hi;
      end
      PIVOT: begin
        pivot_r <= k_dout;
        i_r     <= lo_r;
        j_r     <= lo_r;
      end
      SCAN_RD: begin
        jkey_r <= k_dout;
        if (le_pivot && (i_r == j_r)) begin
          // Key already sits at i, so nothing moves
          i_r <= i_r + 1'b1;
          j_r <= j_r + 1'b1;
        end else if (!le_pivot) begin
          j_r <= j_r + 1'b1;
        end
      end
      SCAN_SW: begin
        if (!ph_r) begin
          ikey_r <= k_dout;
        end else begin
          i_r <= i_r + 1'b1;
          j_r <= j_r + 1'b1;
        end
      end
      FINAL_SW: begin
        if (!ph_r) begin
          ikey_r <= k_dout;
        end else begin
          push_a_r <= '{lo: lo_r, hi: i_r - 1'b1};
          push_b_r <= '{lo: i_r + 1'b1, hi: hi_r};
        end
      end
      default: begin
        jkey_r <= jkey_r;
      end
    endcase
  end

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_r      <= IDLE;
      busy         <= 1'b0;
      done         <= 1'b0;
      ph_r         <= 1'b0;
      push_a_vld_r <= 1'b0;
      push_b_vld_r <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state_r)
        IDLE, DONE: begin
          // Start clears the stack and queues the whole key range
          if (start) begin
            busy         <= 1'b1;
            push_a_vld_r <= 1'b1;
            push_b_vld_r <= 1'b0;
            state_r      <= PUSH;
          end else begin
            state_r <= IDLE;
          end
        end
        POP: begin
          if (empty_r) begin
            busy    <= 1'b0;
            done    <= 1'b1;
            state_r <= DONE;
          end else begin
            state_r <= PIVOT;
          end
        end
        PIVOT: begin
          state_r <= SCAN_RD;
        end
        SCAN_RD: begin
          ph_r <= 1'b0;
          if (le_pivot && (i_r != j_r)) begin
            state_r <= SCAN_SW;
          end else if (last_j) begin
            state_r <= FINAL_SW;
          end
        end
        SCAN_SW: begin
          ph_r <= ~ph_r;
          if (ph_r) begin
            state_r <= last_j ? FINAL_SW : SCAN_RD;
          end
        end
        FINAL_SW: begin
          ph_r <= ~ph_r;
          if (ph_r) begin
            // Only sides with two or more keys need more work
            push_a_vld_r <= ({1'b0, i_r} > {1'b0, lo_r} + 1'b1);
            push_b_vld_r <= ({1'b0, hi_r} > {1'b0, i_r} + 1'b1);
            state_r      <= PUSH;
          end
        end
        PUSH: begin
          if (!full_r) begin
            if (push_a_vld_r) begin
              push_a_vld_r <= 1'b0;
              state_r      <= push_b_vld_r ? PUSH : POP;
            end else begin
              push_b_vld_r <= 1'b0;
              state_r      <= POP;
            end
          end
        end
        default: begin
          state_r <= IDLE;
        end
      endcase
    end
  end

endmodule

/* source/qs_sort_pkg.sv */
// Sort engine types
`include "qs_cfg.svh"

package qs_sort_pkg;

  // Index width follows the key count
  localparam int IDX_W = $clog2(`QS_KEYS);

  // One unsigned key
  typedef logic [`QS_KEY_W-1:0] key_t;

  // Position of a key in the key memory
  typedef logic [IDX_W-1:0] idx_t;

  // Engine FSM states
  typedef enum logic [2:0] {
    IDLE,
    POP,
    PIVOT,
    SCAN_RD,
    SCAN_SW,
    FINAL_SW,
    PUSH,
    DONE
  } eng_state_t;

endpackage

/* source/qs_stack.sv */
// LIFO with registered top entry and SRAM spill
`include "qs_cfg.svh"

module qs_stack
  import qs_stack_pkg::*;
#(
  parameter int N = `QS_STACK_N,
  parameter int W = STACK_W
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         cmd_vld,
  input  logic         cmd_push,
  input  logic [W-1:0] cmd_push_dat,
  input  logic         cmd_clr,
  output logic [W-1:0] cmd_pop_dat_r,
  output logic         empty_r,
  output logic         full_r
);

  localparam int AW = $clog2(N);

  // Top entry lives in cmd_pop_dat_r, the rest in the SRAM
  logic          top_vld_r;
  logic          top_vld_w;
  logic          top_en;
  logic [W-1:0]  top_w;

  // Write pointer counts the words held in the SRAM
  // Read pointer is the slot of the newest of them
  logic [AW-1:0] wr_ptr_r;
  logic [AW-1:0] wr_ptr_w;
  logic [AW-1:0] rd_ptr;
  logic          mem_empty;

  // SRAM port
  logic          sram_en;
  logic          sram_wen;
  logic [AW-1:0] sram_addr;
  logic [W-1:0]  sram_dout;

  assign rd_ptr    = wr_ptr_r - 1'b1;
  assign mem_empty = (wr_ptr_r == '0);

  always_comb begin
    top_vld_w = top_vld_r;
    top_en    = 1'b0;
    top_w     = cmd_push_dat;
    wr_ptr_w  = wr_ptr_r;

    if (cmd_vld) begin
      if (cmd_clr) begin
        // Clear drops everything, the SRAM content is simply forgotten
        top_vld_w = 1'b0;
        wr_ptr_w  = '0;
      end else if (cmd_push) begin
        // A valid top entry spills into the SRAM first
        top_vld_w = 1'b1;
        top_en    = 1'b1;
        if (top_vld_r) begin
          wr_ptr_w = wr_ptr_r + 1'b1;
        end
      end else if (!mem_empty) begin
        // Pop refills the top from the newest SRAM word
        top_en   = 1'b1;
        top_w    = sram_dout;
        wr_ptr_w = rd_ptr;
      end else begin
        top_vld_w = 1'b0;
      end
    end
  end

  // The SRAM is touched only when a word really moves
  assign sram_en   = cmd_vld & ~cmd_clr & (cmd_push ? top_vld_r : ~mem_empty);
  assign sram_wen  = cmd_push;
  assign sram_addr = cmd_push ? wr_ptr_r : rd_ptr;

  // Top entry payload has no reset
  always_ff @(posedge clk) begin
    if (top_en) begin
      cmd_pop_dat_r <= top_w;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      top_vld_r <= 1'b0;
      wr_ptr_r  <= '0;
      empty_r   <= 1'b1;
      full_r    <= 1'b0;
    end else begin
      top_vld_r <= top_vld_w;
      wr_ptr_r  <= wr_ptr_w;
      // Flags follow the next state so they change on the command edge
      empty_r   <= ~top_vld_w;
      full_r    <= top_vld_w & (wr_ptr_w == AW'(N - 1));
    end
  end

  spsram #(
    .W (W),
    .N (N)
  ) u_sram (
    .clk  (clk),
    .en   (sram_en),
    .wen  (sram_wen),
    .addr (sram_addr),
    .din  (cmd_pop_dat_r),
    .dout (sram_dout)
  );

endmodule

/* source/qs_stack_pkg.sv */
// Range stack word types
`include "qs_cfg.svh"

package qs_stack_pkg;

  import qs_sort_pkg::*;

  // A pending index range, both ends inclusive
  typedef struct packed {
    idx_t lo;
    idx_t hi;
  } range_t;

  // One stack word
  // The stack and its SRAM only move the raw bits, while the engine
  // looks at the same bits as a range
  typedef union packed {
    logic [2*IDX_W-1:0] raw;
    range_t             rng;
  } stack_word_u;

  // Width of a stack word
  localparam int STACK_W = $bits(stack_word_u);

endpackage

/* source/qs_top.sv */
// Quicksort accelerator top level
`include "qs_cfg.svh"

module qs_top
  import qs_sort_pkg::*;
  import qs_stack_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic wr_en,
  input  idx_t wr_addr,
  input  key_t wr_dat,
  input  logic start,
  output logic busy,
  output logic done,
  input  idx_t rd_addr,
  output key_t rd_dat
);

  // Engine side of the key memory
  logic k_en;
  logic k_wen;
  idx_t k_addr;
  key_t k_din;

  // Key memory port after the mux
  logic m_en;
  logic m_wen;
  idx_t m_addr;
  key_t m_din;
  key_t m_dout;

  // Engine to stack
  logic               cmd_vld;
  logic               cmd_push;
  logic [STACK_W-1:0] cmd_push_dat;
  logic               cmd_clr;
  logic [STACK_W-1:0] cmd_pop_dat_r;
  logic               empty_r;
  logic               full_r;

  // The engine owns the key memory while busy, the host otherwise
  assign m_en   = busy ? k_en : wr_en;
  assign m_wen  = busy ? k_wen : wr_en;
  assign m_addr = busy ? k_addr : (wr_en ? wr_addr : rd_addr);
  assign m_din  = busy ? k_din : wr_dat;
  assign rd_dat = m_dout;

  qs_engine u_engine (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .k_en          (k_en),
    .k_wen         (k_wen),
    .k_addr        (k_addr),
    .k_din         (k_din),
    .k_dout        (m_dout),
    .cmd_vld       (cmd_vld),
    .cmd_push      (cmd_push),
    .cmd_push_dat  (cmd_push_dat),
    .cmd_clr       (cmd_clr),
    .cmd_pop_dat_r (cmd_pop_dat_r),
    .empty_r       (empty_r),
    .full_r        (full_r)
  );

  qs_stack #(
    .N (`QS_STACK_N),
    .W (STACK_W)
  ) u_stack (
    .clk           (clk),
    .rst           (rst),
    .cmd_vld       (cmd_vld),
    .cmd_push      (cmd_push),
    .cmd_push_dat  (cmd_push_dat),
    .cmd_clr       (cmd_clr),
    .cmd_pop_dat_r (cmd_pop_dat_r),
    .empty_r       (empty_r),
    .full_r        (full_r)
  );

  spsram #(
    .W (`QS_KEY_W),
    .N (`QS_KEYS)
  ) u_keys (
    .clk  (clk),
    .en   (m_en),
    .wen  (m_wen),
    .addr (m_addr),
    .din  (m_din),
    .dout (m_dout)
  );

endmodule

/* source/spsram.sv */
// Single-port SRAM

module spsram #(
  parameter int W = 32,
  parameter int N = 16
) (
  input  logic                 clk,
  input  logic                 en,
  input  logic                 wen,
  input  logic [$clog2(N)-1:0] addr,
  input  logic [W-1:0]         din,
  output logic [W-1:0]         dout
);

  // Storage array
  logic [W-1:0] mem [N];

  // Write lands at the clock edge when both enables are set
  always_ff @(posedge clk) begin
    if (en && wen) begin
      mem[addr] <= din;
    end
  end

  // Read data follows the address in the same cycle
  // During a write cycle this still shows the old word, so a caller
  // can read and replace one location in a single cycle
  assign dout = mem[addr];

endmodule

/* verif/qs_stack_props.sv */
// Range stack usage checks

module qs_stack_props (
  input logic clk,
  input logic rst,
  input logic cmd_vld,
  input logic cmd_push,
  input logic cmd_clr,
  input logic empty_r,
  input logic full_r
);

  // One sticky flag per property
  logic push_full_err = 1'b0;
  logic pop_empty_err = 1'b0;
  logic push_flag_err = 1'b0;
  logic clr_flag_err  = 1'b0;
  logic viol;

  assign viol = push_full_err | pop_empty_err | push_flag_err | clr_flag_err;

  // A push into a full stack would overwrite the oldest spilled range
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (cmd_vld && cmd_push && !cmd_clr) |-> !full_r)
    else begin
      push_full_err = 1'b1;
      $error("Push issued while the stack is full");
    end

  // A pop with nothing stored has no range to return
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    (cmd_vld && !cmd_push && !cmd_clr) |-> !empty_r)
    else begin
      pop_empty_err = 1'b1;
      $error("Pop issued while the stack is empty");
    end

  // The pushed word becomes the top entry at once
  a_push_not_empty: assert property (@(posedge clk) disable iff (rst)
    (cmd_vld && cmd_push && !cmd_clr) |=> !empty_r)
    else begin
      push_flag_err = 1'b1;
      $error("Stack still empty after a push");
    end

  // Clear forgets every entry in one edge
  a_clr_empty: assert property (@(posedge clk) disable iff (rst)
    (cmd_vld && cmd_clr) |=> empty_r)
    else begin
      clr_flag_err = 1'b1;
      $error("Stack not empty after a clear");
    end

endmodule

/* verif/qs_tb.sv */
// Quicksort accelerator regression
`include "qs_cfg.svh"

module qs_tb
  import qs_sort_pkg::*;
();

  localparam int N        = `QS_KEYS;
  localparam int NUM_RUNS = 13;
  // Each run gets a quadratic budget of compare cycles plus load and readback
  localparam int LIMIT    = NUM_RUNS * (`QS_KEYS * `QS_KEYS * 4 + 64);

  logic clk;
  logic rst;
  logic wr_en;
  idx_t wr_addr;
  key_t wr_dat;
  logic start;
  logic busy;
  logic done;
  idx_t rd_addr;
  key_t rd_dat;

  // Last value written to each address, and the expected readback
  key_t cur_keys [N];
  key_t model [$];
  int   cyc_cnt = 0;

  tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

  qs_top UUT (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

  bind qs_stack qs_stack_props u_props (
    .clk      (clk),
    .rst      (rst),
    .cmd_vld  (cmd_vld),
    .cmd_push (cmd_push),
    .cmd_clr  (cmd_clr),
    .empty_r  (empty_r),
    .full_r   (full_r)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch on %s: got 0x%h, expected 0x%h at time %0t",
                          name, got, exp, $time));
    end
  endtask

  // Cycle budget and stack assertion watch
  always @(posedge clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt > LIMIT) begin
      fail_stop("Timeout: the sort did not finish within the cycle budget");
    end
    if (UUT.u_stack.u_props.viol === 1'b1) begin
      fail_stop("A stack usage assertion failed");
    end
  end

  // Modes: 0 random, 1 all equal, 2 ascending, 3 descending, 4 two values
  task automatic make_keys(input int mode);
    key_t base;
    key_t alt;
    base = key_t'($urandom);
    alt  = key_t'($urandom);
    for (int k = 0; k < N; k++) begin
      case (mode)
        0: cur_keys[k] = key_t'($urandom);
        1: cur_keys[k] = base;
        2: cur_keys[k] = key_t'(k * 7 + 1);
        3: cur_keys[k] = key_t'((N - k) * 7);
        default: cur_keys[k] = ($urandom_range(0, 1) == 1) ? alt : base;
      endcase
    end
  endtask

  task automatic write_key(input idx_t a, input key_t v);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= a;
    wr_dat  <= v;
    cur_keys[a] = v;
  endtask

  task automatic end_write();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // Expected readback, in address order or ascending
  task automatic set_model(input bit sorted);
    model.delete();
    foreach (cur_keys[k]) begin
      model.push_back(cur_keys[k]);
    end
    if (sorted) begin
      model.sort();
    end
  endtask

  task automatic load_keys();
    for (int k = 0; k < N; k++) begin
      write_key(idx_t'(k), cur_keys[k]);
    end
    end_write();
    set_model(1'b1);
  endtask

  task automatic read_check();
    for (int a = 0; a < N; a++) begin
      @(posedge clk);
      rd_addr <= idx_t'(a);
      @(negedge clk);
      check("rd_dat", rd_dat, model[a]);
    end
  endtask

  // Start is taken at the second edge, busy shows right after it
  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check("busy", busy, 1);
  endtask

  // Returns at the negedge where done is seen high
  task automatic wait_done();
    @(negedge clk);
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    check("busy", busy, 0);
  endtask

  task automatic sort_and_check();
    pulse_start();
    wait_done();
    @(negedge clk);
    check("done", done, 0);
    read_check();
  endtask

  initial begin
    void'($urandom(96));
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_dat  = '0;
    start   = 1'b0;
    rd_addr = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs after reset, and plain write then read
    @(negedge clk);
    check("busy", busy, 0);
    check("done", done, 0);
    make_keys(0);
    for (int k = 0; k < N; k++) begin
      write_key(idx_t'(k), cur_keys[k]);
    end
    repeat (6) begin
      write_key(idx_t'($urandom_range(0, N - 1)), key_t'($urandom));
    end
    end_write();
    set_model(1'b0);
    read_check();

    // Random keys
    repeat (5) begin
      make_keys(0);
      load_keys();
      sort_and_check();
    end

    // Equal, ascending, descending and two-valued data
    for (int m = 1; m <= 4; m++) begin
      make_keys(m);
      load_keys();
      sort_and_check();
    end

    // Restart in the cycle after done, then a fresh load
    make_keys(0);
    load_keys();
    pulse_start();
    wait_done();
    @(posedge clk);
    start <= 1'b1;
    @(negedge clk);
    check("done", done, 0);
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check("busy", busy, 1);
    wait_done();
    @(negedge clk);
    check("done", done, 0);
    read_check();
    make_keys(0);
    load_keys();
    sort_and_check();

    // A second start while busy must leave no trace
    make_keys(0);
    load_keys();
    pulse_start();
    repeat (3) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_done();
    repeat (4) begin
      @(negedge clk);
      check("done", done, 0);
      check("busy", busy, 0);
    end
    read_check();

    @(negedge clk);
    if (UUT.u_stack.u_props.viol === 1'b1) begin
      fail_stop("A stack usage assertion failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* verif/tb_clock.sv */
// Testbench clock source

module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  // Start low so the first rising edge comes half a period in
  initial begin
    clk = 1'b0;
  end

  // Free-running square wave
  always begin
    #(PERIOD / 2) clk = ~clk;
  end

endmodule
